//--- pe_array_pkg.sv
`default_nettype none

package pe_array_pkg;

    // word width of inputs, parameters, products and sums
    localparam int data_w = 32;

    localparam int rows_default       = 4;
    localparam int lanes_default      = 4;
    localparam int cols_default       = 4;
    localparam int fifo_depth_default = 4;

    // dequantize step
    localparam int dequant_shift = 16;

    typedef enum logic [1:0] {
        mode_direct     = 2'd0,
        mode_column_sum = 2'd1,
        mode_row_sum    = 2'd2,
        mode_total_sum  = 2'd3
    } reduce_mode_e;

endpackage

`default_nettype wire

//--- pe_unit.sv
`default_nettype none

module pe_unit #(
    parameter int LANES = pe_array_pkg::lanes_default
) (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    load,
    input  wire  [LANES*pe_array_pkg::data_w-1:0]  in_row,
    input  wire  [LANES*pe_array_pkg::data_w-1:0]  par_row,
    input  wire                                    shift_right,
    output logic [LANES*pe_array_pkg::data_w-1:0]  vec,
    output logic [pe_array_pkg::data_w-1:0]        scalar
);

    localparam int dw = pe_array_pkg::data_w;

    logic [2*dw-1:0]      prod [LANES];
    logic [LANES*dw-1:0]  vec_d;
    logic [dw-1:0]        sum_d;

    // full-width product, shifted before truncation
    always_comb begin
        sum_d = '0;
        for (int l = 0; l < LANES; l++) begin
            prod[l] = in_row[l*dw +: dw] * par_row[l*dw +: dw];
            if (shift_right) begin
                prod[l] = prod[l] >> pe_array_pkg::dequant_shift;
            end
            vec_d[l*dw +: dw] = prod[l][dw-1:0];
            // wraps at data_w
            sum_d = sum_d + vec_d[l*dw +: dw];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vec    <= '0;
            scalar <= '0;
        end else if (load) begin
            vec    <= vec_d;
            scalar <= sum_d;
        end
    end

endmodule

`default_nettype wire

//--- pe_column.sv
`default_nettype none

module pe_column #(
    parameter int ROWS  = pe_array_pkg::rows_default,
    parameter int LANES = pe_array_pkg::lanes_default
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         in_valid,
    output logic                                        in_ready,
    input  wire  [ROWS*LANES*pe_array_pkg::data_w-1:0]  in_data,
    input  wire  [ROWS*LANES*pe_array_pkg::data_w-1:0]  par_data,
    input  wire  pe_array_pkg::reduce_mode_e            mode,
    input  wire                                         shift_right,
    output logic                                        col_valid,
    input  wire                                         col_ready,
    output logic [ROWS*LANES*pe_array_pkg::data_w-1:0]  col_vec,
    output logic [ROWS*pe_array_pkg::data_w-1:0]        col_scalar,
    output pe_array_pkg::reduce_mode_e                  col_mode
);

    localparam int dw    = pe_array_pkg::data_w;
    localparam int row_w = LANES * dw;

    logic in_fire;

    // stage frees up when empty or draining this cycle
    assign in_ready = !col_valid || col_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            col_valid <= 1'b0;
            col_mode  <= pe_array_pkg::mode_direct;
        end else begin
            if (in_fire) begin
                col_valid <= 1'b1;
                col_mode  <= mode;
            end else if (col_ready) begin
                col_valid <= 1'b0;
            end
        end
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        pe_unit #(
            .LANES(LANES)
        ) i_pe_unit (
            .clk        (clk),
            .rst        (rst),
            .load       (in_fire),
            .in_row     (in_data[r*row_w +: row_w]),
            .par_row    (par_data[r*row_w +: row_w]),
            .shift_right(shift_right),
            .vec        (col_vec[r*row_w +: row_w]),
            .scalar     (col_scalar[r*dw +: dw])
        );
    end

endmodule

`default_nettype wire

//--- result_fifo.sv
`default_nettype none

module result_fifo #(
    parameter int ROWS       = pe_array_pkg::rows_default,
    parameter int LANES      = pe_array_pkg::lanes_default,
    parameter int FIFO_DEPTH = pe_array_pkg::fifo_depth_default
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         col_valid,
    output logic                                        col_ready,
    input  wire  [ROWS*LANES*pe_array_pkg::data_w-1:0]  col_vec,
    input  wire  [ROWS*pe_array_pkg::data_w-1:0]        col_scalar,
    input  wire  pe_array_pkg::reduce_mode_e            col_mode,
    output logic                                        buf_valid,
    input  wire                                         buf_ready,
    output logic [ROWS*LANES*pe_array_pkg::data_w-1:0]  buf_vec,
    output logic [ROWS*pe_array_pkg::data_w-1:0]        buf_scalar,
    output pe_array_pkg::reduce_mode_e                  buf_mode
);

    localparam int dw    = pe_array_pkg::data_w;
    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    logic [ROWS*LANES*dw-1:0]    vec_mem    [FIFO_DEPTH];
    logic [ROWS*dw-1:0]          scalar_mem [FIFO_DEPTH];
    pe_array_pkg::reduce_mode_e  mode_mem   [FIFO_DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_fire;
    logic             rd_fire;

    assign col_ready = (count != cnt_w'(FIFO_DEPTH));
    assign buf_valid = (count != '0);
    assign wr_fire   = col_valid && col_ready;
    assign rd_fire   = buf_valid && buf_ready;

    assign buf_vec    = vec_mem[rd_ptr];
    assign buf_scalar = scalar_mem[rd_ptr];
    assign buf_mode   = mode_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            vec_mem[wr_ptr]    <= col_vec;
            scalar_mem[wr_ptr] <= col_scalar;
            mode_mem[wr_ptr]   <= col_mode;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy only moves when one side fires alone
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- row_reducer.sv
`default_nettype none

module row_reducer #(
    parameter int ROWS  = pe_array_pkg::rows_default,
    parameter int LANES = pe_array_pkg::lanes_default,
    parameter int COLS  = pe_array_pkg::cols_default
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         buf_valid,
    output logic                                        buf_ready,
    input  wire  [ROWS*LANES*pe_array_pkg::data_w-1:0]  buf_vec,
    input  wire  [ROWS*pe_array_pkg::data_w-1:0]        buf_scalar,
    input  wire  pe_array_pkg::reduce_mode_e            buf_mode,
    output logic                                        out_valid,
    input  wire                                         out_ready,
    output logic [ROWS*LANES*pe_array_pkg::data_w-1:0]  out_vec,
    output logic [ROWS*pe_array_pkg::data_w-1:0]        out_scalar
);

    localparam int dw    = pe_array_pkg::data_w;
    localparam int cnt_w = (COLS > 1) ? $clog2(COLS) : 1;

    logic [cnt_w-1:0]         col_cnt;
    logic [ROWS*LANES*dw-1:0] acc_vec;
    logic [ROWS*dw-1:0]       acc_scalar;
    logic [ROWS*LANES*dw-1:0] acc_next_vec;
    logic [ROWS*dw-1:0]       acc_next_scalar;
    logic [LANES*dw-1:0]      col_sum_vec;
    logic [dw-1:0]            col_sum_scalar;
    logic [LANES*dw-1:0]      tot_vec;
    logic [dw-1:0]            tot_scalar;
    logic [ROWS*LANES*dw-1:0] res_vec;
    logic [ROWS*dw-1:0]       res_scalar;
    logic                     buf_fire;
    logic                     last_col;
    logic                     accum_mode;
    logic                     emit;

    assign buf_ready  = !out_valid || out_ready;
    assign buf_fire   = buf_valid && buf_ready;
    assign last_col   = (col_cnt == cnt_w'(COLS - 1));
    assign accum_mode = (buf_mode == pe_array_pkg::mode_row_sum) ||
                        (buf_mode == pe_array_pkg::mode_total_sum);
    // accumulating modes only emit on the last column of a group
    assign emit       = buf_fire && (!accum_mode || last_col);

    always_comb begin
        col_sum_vec    = '0;
        col_sum_scalar = '0;
        tot_vec        = '0;
        tot_scalar     = '0;
        for (int r = 0; r < ROWS; r++) begin
            acc_next_scalar[r*dw +: dw] = acc_scalar[r*dw +: dw] + buf_scalar[r*dw +: dw];
            col_sum_scalar = col_sum_scalar + buf_scalar[r*dw +: dw];
            tot_scalar     = tot_scalar + acc_next_scalar[r*dw +: dw];
            for (int l = 0; l < LANES; l++) begin
                acc_next_vec[(r*LANES+l)*dw +: dw] = acc_vec[(r*LANES+l)*dw +: dw] +
                                                     buf_vec[(r*LANES+l)*dw +: dw];
                col_sum_vec[l*dw +: dw] = col_sum_vec[l*dw +: dw] +
                                          buf_vec[(r*LANES+l)*dw +: dw];
                tot_vec[l*dw +: dw] = tot_vec[l*dw +: dw] +
                                      acc_next_vec[(r*LANES+l)*dw +: dw];
            end
        end
    end

    // summed modes land in row 0, other rows stay zero
    always_comb begin
        res_vec    = '0;
        res_scalar = '0;
        case (buf_mode)
            pe_array_pkg::mode_direct: begin
                res_vec    = buf_vec;
                res_scalar = buf_scalar;
            end
            pe_array_pkg::mode_column_sum: begin
                res_vec[LANES*dw-1:0] = col_sum_vec;
                res_scalar[dw-1:0]    = col_sum_scalar;
            end
            pe_array_pkg::mode_row_sum: begin
                res_vec    = acc_next_vec;
                res_scalar = acc_next_scalar;
            end
            pe_array_pkg::mode_total_sum: begin
                res_vec[LANES*dw-1:0] = tot_vec;
                res_scalar[dw-1:0]    = tot_scalar;
            end
            default: begin
                res_vec    = '0;
                res_scalar = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            col_cnt    <= '0;
            acc_vec    <= '0;
            acc_scalar <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (buf_fire) begin
                col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                // clears itself once the group result goes out
                acc_vec    <= (accum_mode && !last_col) ? acc_next_vec : '0;
                acc_scalar <= (accum_mode && !last_col) ? acc_next_scalar : '0;
            end
            if (emit) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            out_vec    <= res_vec;
            out_scalar <= res_scalar;
        end
    end

endmodule

`default_nettype wire

//--- pe_array_top.sv
`default_nettype none

module pe_array_top #(
    parameter int ROWS       = pe_array_pkg::rows_default,
    parameter int LANES      = pe_array_pkg::lanes_default,
    parameter int COLS       = pe_array_pkg::cols_default,
    parameter int FIFO_DEPTH = pe_array_pkg::fifo_depth_default
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         in_valid,
    output logic                                        in_ready,
    input  wire  [ROWS*LANES*pe_array_pkg::data_w-1:0]  in_data,
    input  wire  [ROWS*LANES*pe_array_pkg::data_w-1:0]  par_data,
    input  wire  pe_array_pkg::reduce_mode_e            mode,
    input  wire                                         shift_right,
    output logic                                        out_valid,
    input  wire                                         out_ready,
    output logic [ROWS*LANES*pe_array_pkg::data_w-1:0]  out_vec,
    output logic [ROWS*pe_array_pkg::data_w-1:0]        out_scalar
);

    localparam int dw = pe_array_pkg::data_w;

    logic                       col_valid;
    logic                       col_ready;
    logic [ROWS*LANES*dw-1:0]   col_vec;
    logic [ROWS*dw-1:0]         col_scalar;
    pe_array_pkg::reduce_mode_e col_mode;
    logic                       buf_valid;
    logic                       buf_ready;
    logic [ROWS*LANES*dw-1:0]   buf_vec;
    logic [ROWS*dw-1:0]         buf_scalar;
    pe_array_pkg::reduce_mode_e buf_mode;

    pe_column #(
        .ROWS (ROWS),
        .LANES(LANES)
    ) i_pe_column (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .par_data   (par_data),
        .mode       (mode),
        .shift_right(shift_right),
        .col_valid  (col_valid),
        .col_ready  (col_ready),
        .col_vec    (col_vec),
        .col_scalar (col_scalar),
        .col_mode   (col_mode)
    );

    result_fifo #(
        .ROWS      (ROWS),
        .LANES     (LANES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_result_fifo (
        .clk       (clk),
        .rst       (rst),
        .col_valid (col_valid),
        .col_ready (col_ready),
        .col_vec   (col_vec),
        .col_scalar(col_scalar),
        .col_mode  (col_mode),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready),
        .buf_vec   (buf_vec),
        .buf_scalar(buf_scalar),
        .buf_mode  (buf_mode)
    );

    row_reducer #(
        .ROWS (ROWS),
        .LANES(LANES),
        .COLS (COLS)
    ) i_row_reducer (
        .clk       (clk),
        .rst       (rst),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready),
        .buf_vec   (buf_vec),
        .buf_scalar(buf_scalar),
        .buf_mode  (buf_mode),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_vec   (out_vec),
        .out_scalar(out_scalar)
    );

endmodule

`default_nettype wire

//--- pe_array_props.sv
`default_nettype none

module pe_array_props #(
    parameter int ROWS  = pe_array_pkg::rows_default,
    parameter int LANES = pe_array_pkg::lanes_default
) (
    input wire                                        clk,
    input wire                                        rst,
    input wire                                        in_ready,
    input wire                                        out_valid,
    input wire                                        out_ready,
    input wire [ROWS*LANES*pe_array_pkg::data_w-1:0]  out_vec,
    input wire [ROWS*pe_array_pkg::data_w-1:0]        out_scalar
);

    timeunit 1ns;
    timeprecision 1ps;

    // held result may not move while stalled
    assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_vec) && $stable(out_scalar))
    else $error("output changed while out_ready was low");

    assert property (@(posedge clk) (!rst || $rose(rst)) |-> in_ready && !out_valid)
    else $error("in_ready low or out_valid high around reset");

    assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> !$isunknown(out_vec) && !$isunknown(out_scalar))
    else $error("out_valid high with unknown output data");

endmodule

bind pe_array_top pe_array_props #(
    .ROWS (ROWS),
    .LANES(LANES)
) i_pe_array_props (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_vec   (out_vec),
    .out_scalar(out_scalar)
);

`default_nettype wire

//--- pe_array_tb.sv
`default_nettype none

module pe_array_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int dw    = pe_array_pkg::data_w;
    localparam int rows  = pe_array_pkg::rows_default;
    localparam int lanes = pe_array_pkg::lanes_default;
    localparam int words = rows * lanes;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic                       in_ready;
    logic [words*dw-1:0]        in_data;
    logic [words*dw-1:0]        par_data;
    pe_array_pkg::reduce_mode_e mode;
    logic                       shift_right;
    logic                       out_valid;
    logic                       out_ready;
    logic [words*dw-1:0]        out_vec;
    logic [rows*dw-1:0]         out_scalar;

    logic [words*dw-1:0]        in_q         [$];
    logic [words*dw-1:0]        par_q        [$];
    pe_array_pkg::reduce_mode_e mode_q       [$];
    logic                       shift_q      [$];
    logic [words*dw-1:0]        exp_vec_q    [$];
    logic [rows*dw-1:0]         exp_scalar_q [$];

    integer seed = 32'h108e_1469;
    int     vec_errors;
    int     scalar_errors;
    int     other_errors;
    int     results_seen;
    int     results_expected;
    logic   loaded;

    pe_array_top #(
        .ROWS      (rows),
        .LANES     (lanes),
        .COLS      (pe_array_pkg::cols_default),
        .FIFO_DEPTH(pe_array_pkg::fifo_depth_default)
    ) i_pe_array_top (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .par_data   (par_data),
        .mode       (mode),
        .shift_right(shift_right),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_vec    (out_vec),
        .out_scalar (out_scalar)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic read_patterns();
        int                  fd;
        int                  code;
        int                  bad;
        int                  mode_val;
        int                  shift_val;
        logic [7:0]          tag;
        logic [dw-1:0]       word;
        logic [words*dw-1:0] a;
        logic [words*dw-1:0] b;
        logic [rows*dw-1:0]  s;
        logic [8*160-1:0]    skip_line;
        bad = 0;
        fd = $fopen("pe_array_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open pe_array_patterns.txt");
            other_errors++;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(skip_line, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%d %d", mode_val, shift_val);
                if (code != 2) begin
                    bad++;
                end
                for (int i = 0; i < words; i++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        bad++;
                    end
                    a[i*dw +: dw] = word;
                end
                for (int i = 0; i < words; i++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        bad++;
                    end
                    b[i*dw +: dw] = word;
                end
                in_q.push_back(a);
                par_q.push_back(b);
                mode_q.push_back(pe_array_pkg::reduce_mode_e'(mode_val));
                shift_q.push_back(shift_val[0]);
            end else if (tag == "E") begin
                for (int i = 0; i < words; i++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        bad++;
                    end
                    a[i*dw +: dw] = word;
                end
                for (int i = 0; i < rows; i++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        bad++;
                    end
                    s[i*dw +: dw] = word;
                end
                exp_vec_q.push_back(a);
                exp_scalar_q.push_back(s);
            end else begin
                $display("unknown record type in pe_array_patterns.txt");
                other_errors++;
            end
        end
        $fclose(fd);
        if (bad != 0) begin
            $display("pe_array_patterns.txt has %0d missing or unreadable fields", bad);
            other_errors++;
        end
    endtask

    task automatic check_vec(
        input logic [words*dw-1:0] got,
        input logic [words*dw-1:0] exp,
        input int                  idx
    );
        for (int w = 0; w < words; w++) begin
            if (got[w*dw +: dw] !== exp[w*dw +: dw]) begin
                $display("FAIL %0t: result %0d out_vec row %0d lane %0d is %h, expected %h",
                         $time, idx, w / lanes, w % lanes, got[w*dw +: dw], exp[w*dw +: dw]);
                vec_errors++;
            end
        end
    endtask

    task automatic check_scalar(
        input logic [rows*dw-1:0] got,
        input logic [rows*dw-1:0] exp,
        input int                 idx
    );
        for (int r = 0; r < rows; r++) begin
            if (got[r*dw +: dw] !== exp[r*dw +: dw]) begin
                $display("FAIL %0t: result %0d out_scalar row %0d is %h, expected %h",
                         $time, idx, r, got[r*dw +: dw], exp[r*dw +: dw]);
                scalar_errors++;
            end
        end
    endtask

    task automatic send_column(input int idx);
        @(negedge clk);
        in_valid    = 1'b1;
        in_data     = in_q[idx];
        par_data    = par_q[idx];
        mode        = mode_q[idx];
        shift_right = shift_q[idx];
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic print_counts();
        $display("errors: out_vec %0d, out_scalar %0d, other %0d, results %0d of %0d",
                 vec_errors, scalar_errors, other_errors, results_seen, results_expected);
    endtask

    // random back-pressure, about one stall in four
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = (($random(seed) & 3) != 0);
        end
    end

    always @(posedge clk) begin
        if (rst && out_valid && out_ready) begin
            if (exp_vec_q.size() == 0) begin
                $display("an output arrived at %0t after all expected results were used", $time);
                other_errors++;
            end else begin
                check_vec(out_vec, exp_vec_q.pop_front(), results_seen);
                check_scalar(out_scalar, exp_scalar_q.pop_front(), results_seen);
            end
            results_seen++;
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (in_q.size() + results_expected) * 20 + 40;
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles", limit);
        print_counts();
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst              = 1'b0;
        in_valid         = 1'b0;
        in_data          = '0;
        par_data         = '0;
        mode             = pe_array_pkg::mode_direct;
        shift_right      = 1'b0;
        vec_errors       = 0;
        scalar_errors    = 0;
        other_errors     = 0;
        results_seen     = 0;
        loaded           = 1'b0;
        read_patterns();
        results_expected = exp_vec_q.size();
        loaded           = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        if (!in_ready || out_valid) begin
            $display("in_ready or out_valid had the wrong level while reset was held");
            other_errors++;
        end
        rst = 1'b1;
        for (int i = 0; i < in_q.size(); i++) begin
            send_column(i);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait (results_seen >= results_expected);
        // catch any extra result
        repeat (20) @(posedge clk);
        print_counts();
        if (vec_errors == 0 && scalar_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pe_array_patterns.txt
# I mode shift, then 16 in words and 16 par words in hex, word = row*4 + lane
# E then 16 out_vec words and 4 out_scalar words in hex, in output order
I 0 0 1 2 3 4 5 6 7 8 9 a b c d e f 1  1 1 1 1 2 2 2 2 3 3 3 3 1 2 3 4
E 1 2 3 4 a c e 10 1b 1e 21 24 d 1c 2d 4  a 34 7e 5a
I 0 0 2 3 4 5 6 7 8 9 a b c d e f 0 1  f e d c b a 9 8 7 6 5 4 3 2 1 0
E 1e 2a 34 3c 42 46 48 48 46 42 3c 34 2a 1e 0 0  b8 118 f8 48
I 0 1 10000 20000 30000 40000 18000 18000 18000 18000
  ffff ffff ffff ffff 80000000 80000000 1 0
  1 2 3 4 1 2 3 4 1 2 3 10000 4 10 1 0
E 1 4 9 10 1 3 4 6 0 1 2 ffff 20000 80000 0 0  1e e 10002 a0000
I 0 0 ffffffff ffffffff 0 0 1 1 1 1 0 0 0 0 3 3 3 3  2 1 0 0 1 1 1 1 5 5 5 5 3 3 3 3
E fffffffe ffffffff 0 0 1 1 1 1 0 0 0 0 9 9 9 9  fffffffd 4 0 24
I 1 0 1 2 3 4 5 6 7 8 9 a b c d e f 1  1 1 1 1 2 2 2 2 3 3 3 3 1 2 3 4
E 33 48 5f 3c 0 0 0 0 0 0 0 0 0 0 0 0  116 0 0 0
I 1 0 2 3 4 5 6 7 8 9 a b c d e f 0 1  f e d c b a 9 8 7 6 5 4 3 2 1 0
E d0 d0 b8 b8 0 0 0 0 0 0 0 0 0 0 0 0  310 0 0 0
I 1 0 ffffffff ffffffff 0 0 1 1 1 1 0 0 0 0 3 3 3 3  2 1 0 0 1 1 1 1 5 5 5 5 3 3 3 3
E 8 9 a a 0 0 0 0 0 0 0 0 0 0 0 0  25 0 0 0
I 1 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1  1 2 3 4 5 6 7 8 9 a b c d e f 10
E 1c 20 24 28 0 0 0 0 0 0 0 0 0 0 0 0  88 0 0 0
I 2 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1  1 2 3 4 5 6 7 8 9 a b c d e f 10
I 2 0 1 2 3 4 5 6 7 8 9 a b c d e f 1  1 1 1 1 2 2 2 2 3 3 3 3 1 2 3 4
I 2 0 2 3 4 5 6 7 8 9 a b c d e f 0 1  f e d c b a 9 8 7 6 5 4 3 2 1 0
I 2 0 ffffffff ffffffff 0 0 1 1 1 1 0 0 0 0 3 3 3 3  2 1 0 0 1 1 1 1 5 5 5 5 3 3 3 3
E 1e 2d 3a 44 52 59 5e 61 6a 6a 68 64 4d 51 45 1d  c9 16a 1a0 100
I 3 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1  1 2 3 4 5 6 7 8 9 a b c d e f 10
I 3 0 1 2 3 4 5 6 7 8 9 a b c d e f 1  1 1 1 1 2 2 2 2 3 3 3 3 1 2 3 4
I 3 0 2 3 4 5 6 7 8 9 a b c d e f 0 1  f e d c b a 9 8 7 6 5 4 3 2 1 0
I 3 0 ffffffff ffffffff 0 0 1 1 1 1 0 0 0 0 3 3 3 3  2 1 0 0 1 1 1 1 5 5 5 5 3 3 3 3
E 127 141 145 126 0 0 0 0 0 0 0 0 0 0 0 0  4d3 0 0 0

//--- tb.f
pe_array_pkg.sv
pe_unit.sv
pe_column.sv
result_fifo.sv
row_reducer.sv
pe_array_top.sv
pe_array_props.sv
pe_array_tb.sv

//--- Bender.yml
package:
  name: pe_array

sources:
  - files:
      - pe_array_pkg.sv
      - pe_unit.sv
      - pe_column.sv
      - result_fifo.sv
      - row_reducer.sv
      - pe_array_top.sv
  - target: test
    files:
      - pe_array_props.sv
      - pe_array_tb.sv
